// File: rtl/pcieSubConsts.svh
`ifndef PCIE_SUB_CONSTS_SVH
`define PCIE_SUB_CONSTS_SVH

// Bus and buffer widths
`define AXI_ADDR_W    64
`define AXI_DATA_W    128
`define WORD_W        32
`define BLOCK_WORDS   8
`define BUF_ADDR_W    3

// Idle poll interval, terminal count of the timer
`define POLL_PERIOD   32

// Host descriptor layout
`define PROD_PTR_ADDR 64'h10
`define CONS_PTR_ADDR 64'h0
`define INIT_SLOT     1
`define SLOT_LSB      12
`define SLOT_COUNT    8
`define WORD_STRIDE   64'h10

`endif

// File: rtl/axiPkg.sv
package axiPkg;
   `include "pcieSubConsts.svh"

   typedef logic [`AXI_ADDR_W-1:0] axiAddr_t;
   typedef logic [`AXI_DATA_W-1:0] axiData_t;
   typedef logic [1:0]             axiResp_t;

   typedef struct packed {
      logic       valid;
      axiAddr_t   addr;
      logic [7:0] len;
      logic [2:0] size;
      logic [1:0] burst;
      logic [3:0] id;
      logic       lock;
      logic [3:0] cache;
      logic [2:0] prot;
      logic [3:0] qos;
   } axiAr_t;

   typedef struct packed {
      logic     valid;
      axiData_t data;
      axiResp_t resp;
      logic     last;
   } axiR_t;

   // Write address carries the same fields as read address
   typedef axiAr_t axiAw_t;

   typedef struct packed {
      logic                      valid;
      axiData_t                  data;
      logic [`AXI_DATA_W/8-1:0]  strb;
      logic                      last;
   } axiW_t;

   typedef struct packed {
      logic     valid;
      axiResp_t resp;
   } axiB_t;

   typedef enum logic [1:0] {rdIdle, rdAddr, rdData} rdState_t;

   typedef enum logic [2:0] {wrIdle, wrBoth, wrDataOnly, wrAddrOnly, wrResp} wrState_t;
endpackage

// File: rtl/fetchPkg.sv
package fetchPkg;
   `include "pcieSubConsts.svh"

   typedef logic [$clog2(`SLOT_COUNT)-1:0] slot_t;
   typedef logic [`WORD_W-1:0]             word_t;
   typedef logic [`BUF_ADDR_W-1:0]         bufAddr_t;

   typedef struct packed {
      logic              valid;
      axiPkg::axiAddr_t  addr;
      axiPkg::axiData_t  data;
   } memRq_t;

   typedef struct packed {
      logic              done;
      logic              err;
      axiPkg::axiData_t  data;
   } memRsp_t;

   typedef enum logic [2:0] {idle, loadPtr, fetch, updatePtr, handoff} fetchState_t;
endpackage

// File: rtl/axiReadReq.sv
`timescale 1ns/1ps

module axiReadReq (
   input  logic              clk,
   input  logic              rst_n,
   input  fetchPkg::memRq_t  rq,
   output fetchPkg::memRsp_t rsp,
   output axiPkg::axiAr_t    ar,
   input  logic              arReady,
   input  axiPkg::axiR_t     r,
   output logic              rReady
);
   import axiPkg::*;

   rdState_t state;
   axiAddr_t addrQ;
   axiData_t dataQ;
   logic     errQ;
   logic     doneQ;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= rdIdle;
         doneQ <= 1'b0;
      end else begin
         doneQ <= 1'b0;
         case (state)
            rdIdle: begin
               if (rq.valid) begin
                  state <= rdAddr;
               end
            end
            rdAddr: begin
               if (arReady) begin
                  state <= rdData;
               end
            end
            rdData: begin
               if (r.valid) begin
                  state <= rdIdle;
                  doneQ <= 1'b1;
               end
            end
            default: state <= rdIdle;
         endcase
      end
   end

   // Request address and returned beat
   always_ff @(posedge clk) begin
      if (state == rdIdle && rq.valid) begin
         addrQ <= rq.addr;
      end
      if (r.valid && rReady) begin
         dataQ <= r.data;
         errQ  <= (r.resp != axiResp_t'(0));
      end
   end

   always_comb begin
      ar       = '0;
      ar.valid = (state == rdAddr);
      ar.addr  = addrQ;
      ar.len   = 8'd0;
      ar.size  = 3'd4;
      ar.burst = 2'b01;
      ar.prot  = 3'd2;
   end

   assign rReady = (state == rdData);
   assign rsp    = '{done: doneQ, err: errQ, data: dataQ};

   arHoldA: assert property (@(posedge clk) disable iff (!rst_n)
      ar.valid && !arReady |=> ar.valid && $stable(ar.addr));
endmodule

// File: rtl/axiWriteReq.sv
`timescale 1ns/1ps

module axiWriteReq (
   input  logic              clk,
   input  logic              rst_n,
   input  fetchPkg::memRq_t  rq,
   output fetchPkg::memRsp_t rsp,
   output axiPkg::axiAw_t    aw,
   input  logic              awReady,
   output axiPkg::axiW_t     w,
   input  logic              wReady,
   input  axiPkg::axiB_t     b,
   output logic              bReady
);
   import axiPkg::*;

   wrState_t state;
   axiAddr_t addrQ;
   axiData_t dataQ;
   logic     errQ;
   logic     doneQ;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= wrIdle;
         doneQ <= 1'b0;
      end else begin
         doneQ <= 1'b0;
         case (state)
            wrIdle: begin
               if (rq.valid) begin
                  state <= wrBoth;
               end
            end
            wrBoth: begin
               case ({awReady, wReady})
                  2'b11:   state <= wrResp;
                  2'b10:   state <= wrDataOnly;
                  2'b01:   state <= wrAddrOnly;
                  default: state <= wrBoth;
               endcase
            end
            // Address gone, data beat still pending
            wrDataOnly: begin
               if (wReady) begin
                  state <= wrResp;
               end
            end
            wrAddrOnly: begin
               if (awReady) begin
                  state <= wrResp;
               end
            end
            wrResp: begin
               if (b.valid) begin
                  state <= wrIdle;
                  doneQ <= 1'b1;
               end
            end
            default: state <= wrIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == wrIdle && rq.valid) begin
         addrQ <= rq.addr;
         dataQ <= rq.data;
      end
      if (b.valid && bReady) begin
         errQ <= (b.resp != axiResp_t'(0));
      end
   end

   always_comb begin
      aw       = '0;
      aw.valid = (state == wrBoth) || (state == wrAddrOnly);
      aw.addr  = addrQ;
      aw.len   = 8'd0;
      aw.size  = 3'd4;
      aw.burst = 2'b01;
      aw.prot  = 3'd2;
   end

   assign w.valid = (state == wrBoth) || (state == wrDataOnly);
   assign w.data  = dataQ;
   assign w.strb  = '1;
   assign w.last  = 1'b1;

   assign bReady = (state == wrResp);
   assign rsp    = '{done: doneQ, err: errQ, data: '0};

   noDataInRespA: assert property (@(posedge clk) disable iff (!rst_n)
      state == wrResp |-> !w.valid);
endmodule

// File: rtl/ibBuffer.sv
`timescale 1ns/1ps

`include "pcieSubConsts.svh"

module ibBuffer (
   input  logic               clk,
   input  logic               wrEn,
   input  fetchPkg::bufAddr_t wrAddr,
   input  fetchPkg::word_t    wrData,
   input  logic               rdEn,
   input  fetchPkg::bufAddr_t rdAddr,
   output fetchPkg::word_t    rdData
);
   import fetchPkg::*;

   word_t mem [`BLOCK_WORDS];

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
      // Registered read, data one cycle after rdEn
      if (rdEn) begin
         rdData <= mem[rdAddr];
      end
   end
endmodule

// File: rtl/ibFetchCtlr.sv
`timescale 1ns/1ps

`include "pcieSubConsts.svh"

module ibFetchCtlr (
   input  logic               clk,
   input  logic               rst_n,
   output fetchPkg::memRq_t   rdRq,
   input  fetchPkg::memRsp_t  rdRsp,
   output fetchPkg::memRq_t   wrRq,
   input  fetchPkg::memRsp_t  wrRsp,
   output logic               bufWrEn,
   output fetchPkg::bufAddr_t bufWrAddr,
   output fetchPkg::word_t    bufWrData,
   output logic               blockReady,
   input  logic               blockDone
);
   import axiPkg::*;
   import fetchPkg::*;

   localparam int PollW = $clog2(`POLL_PERIOD + 1);

   fetchState_t      state;
   logic [PollW-1:0] pollCnt;
   slot_t            consSlot;
   slot_t            nextSlot;
   bufAddr_t         wordIdx;
   axiAddr_t         readAddr;
   axiAddr_t         slotBase;
   logic             readValid;
   logic             writeValid;
   logic             readOk;
   logic             slotHit;
   logic             lastWord;
   logic             readOpen;

   assign nextSlot = (consSlot == slot_t'(`SLOT_COUNT - 1)) ? '0 : consSlot + 1'b1;
   assign slotBase = axiAddr_t'(consSlot) << `SLOT_LSB;
   assign readOk   = rdRsp.done && !rdRsp.err;
   assign slotHit  = rdRsp.data[`SLOT_LSB +: 4] == 4'(consSlot);
   assign lastWord = (wordIdx == bufAddr_t'(`BLOCK_WORDS - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pollCnt <= '0;
      end else if (pollCnt == PollW'(`POLL_PERIOD)) begin
         pollCnt <= '0;
      end else begin
         pollCnt <= pollCnt + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= idle;
         consSlot   <= slot_t'(`INIT_SLOT);
         wordIdx    <= '0;
         readValid  <= 1'b0;
         writeValid <= 1'b0;
         bufWrEn    <= 1'b0;
         blockReady <= 1'b0;
      end else begin
         readValid  <= 1'b0;
         writeValid <= 1'b0;
         bufWrEn    <= 1'b0;
         case (state)
            idle: begin
               if (pollCnt == PollW'(`POLL_PERIOD)) begin
                  readValid <= 1'b1;
                  state     <= loadPtr;
               end
            end
            loadPtr: begin
               if (rdRsp.done && rdRsp.err) begin
                  readValid <= 1'b1;
               end else if (readOk && slotHit) begin
                  state <= idle;
               end else if (readOk) begin
                  readValid <= 1'b1;
                  wordIdx   <= '0;
                  state     <= fetch;
               end
            end
            fetch: begin
               if (rdRsp.done && rdRsp.err) begin
                  readValid <= 1'b1;
               end else if (readOk) begin
                  bufWrEn <= 1'b1;
                  if (lastWord) begin
                     writeValid <= 1'b1;
                     state      <= updatePtr;
                  end else begin
                     wordIdx   <= wordIdx + 1'b1;
                     readValid <= 1'b1;
                  end
               end
            end
            updatePtr: begin
               if (wrRsp.done && wrRsp.err) begin
                  writeValid <= 1'b1;
               end else if (wrRsp.done) begin
                  consSlot   <= nextSlot;
                  blockReady <= 1'b1;
                  state      <= handoff;
               end
            end
            handoff: begin
               if (blockDone) begin
                  blockReady <= 1'b0;
                  state      <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // Fetch address steps only on a clean beat, so a failed one repeats
   always_ff @(posedge clk) begin
      bufWrAddr <= wordIdx;
      bufWrData <= rdRsp.data[`WORD_W-1:0];
      case (state)
         idle:    readAddr <= `PROD_PTR_ADDR;
         loadPtr: begin
            if (readOk) begin
               readAddr <= slotBase;
            end
         end
         fetch: begin
            if (readOk) begin
               readAddr <= readAddr + `WORD_STRIDE;
            end
         end
         default: readAddr <= readAddr;
      endcase
   end

   assign rdRq = '{valid: readValid, addr: readAddr, data: '0};
   assign wrRq = '{valid: writeValid, addr: `CONS_PTR_ADDR,
                   data: axiData_t'(nextSlot) << `SLOT_LSB};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         readOpen <= 1'b0;
      end else if (rdRq.valid) begin
         readOpen <= 1'b1;
      end else if (rdRsp.done) begin
         readOpen <= 1'b0;
      end
   end

   oneReadA: assert property (@(posedge clk) disable iff (!rst_n)
      readOpen |-> !rdRq.valid);
endmodule

// File: rtl/pcieSubTop.sv
`timescale 1ns/1ps

module pcieSubTop (
   input  logic               clk,
   input  logic               rst_n,
   output axiPkg::axiAr_t     ar,
   input  logic               arReady,
   input  axiPkg::axiR_t      r,
   output logic               rReady,
   output axiPkg::axiAw_t     aw,
   input  logic               awReady,
   output axiPkg::axiW_t      w,
   input  logic               wReady,
   input  axiPkg::axiB_t      b,
   output logic               bReady,
   output logic               blockReady,
   input  logic               blockDone,
   input  logic               bufRdEn,
   input  fetchPkg::bufAddr_t bufRdAddr,
   output fetchPkg::word_t    bufRdData
);
   import fetchPkg::*;

   memRq_t   rdRq;
   memRq_t   wrRq;
   memRsp_t  rdRsp;
   memRsp_t  wrRsp;
   logic     bufWrEn;
   bufAddr_t bufWrAddr;
   word_t    bufWrData;

   ibFetchCtlr ctlr0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .rdRq       (rdRq),
      .rdRsp      (rdRsp),
      .wrRq       (wrRq),
      .wrRsp      (wrRsp),
      .bufWrEn    (bufWrEn),
      .bufWrAddr  (bufWrAddr),
      .bufWrData  (bufWrData),
      .blockReady (blockReady),
      .blockDone  (blockDone)
   );

   ibBuffer buf0 (
      .clk    (clk),
      .wrEn   (bufWrEn),
      .wrAddr (bufWrAddr),
      .wrData (bufWrData),
      .rdEn   (bufRdEn),
      .rdAddr (bufRdAddr),
      .rdData (bufRdData)
   );

   axiReadReq rdReq0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .rq      (rdRq),
      .rsp     (rdRsp),
      .ar      (ar),
      .arReady (arReady),
      .r       (r),
      .rReady  (rReady)
   );

   axiWriteReq wrReq0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .rq      (wrRq),
      .rsp     (wrRsp),
      .aw      (aw),
      .awReady (awReady),
      .w       (w),
      .wReady  (wReady),
      .b       (b),
      .bReady  (bReady)
   );
endmodule

// File: verification/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
   parameter int PeriodNs = 40
) (
   output logic clk
);
   initial begin
      clk = 1'b0;
      forever #(PeriodNs / 2) clk = ~clk;
   end
endmodule

// File: verification/pcieSubTb.sv
`timescale 1ns/1ps

`include "pcieSubConsts.svh"

module pcieSubTb;
   import axiPkg::*;
   import fetchPkg::*;

   localparam int ClkPeriod  = 40;
   localparam int PollCycles = `POLL_PERIOD + 1;
   localparam int NumRows    = 9;
   localparam int NoErr      = `BLOCK_WORDS;
   localparam int WatchdogCycles = NumRows * (3 * PollCycles + (`BLOCK_WORDS + 2) * 12);

   // Producer slot, errored read word, pointer write error, consumer slot afterwards
   typedef struct packed {
      int prodSlot;
      int errWord;
      bit wrErr;
      int expSlot;
   } row_t;

   typedef struct packed {
      axiAddr_t                 addr;
      axiData_t                 data;
      logic [`AXI_DATA_W/8-1:0] strb;
      logic                     last;
   } wrRec_t;

   string rowName [NumRows] = '{"noopStart", "fetchSlot1", "readRetry", "writeRetry",
      "fetchSlot4", "bothRetry", "lastRetry", "wrapSlot7", "noopSlot0"};
   row_t rows [NumRows] = '{
      '{1, NoErr, 1'b0, 1},
      '{5, NoErr, 1'b0, 2},
      '{5, 3,     1'b0, 3},
      '{5, NoErr, 1'b1, 4},
      '{0, NoErr, 1'b0, 5},
      '{0, 6,     1'b1, 6},
      '{0, 7,     1'b0, 7},
      '{3, 0,     1'b0, 0},
      '{0, NoErr, 1'b0, 0}
   };

   logic     clk;
   logic     rst_n;
   axiAr_t   ar;
   logic     arReady = 1'b0;
   axiR_t    r = '0;
   logic     rReady;
   axiAw_t   aw;
   logic     awReady = 1'b0;
   axiW_t    w;
   logic     wReady = 1'b0;
   axiB_t    b = '0;
   logic     bReady;
   logic     blockReady;
   logic     blockDone;
   logic     bufRdEn;
   bufAddr_t bufRdAddr;
   word_t    bufRdData;

   // Host memory model state
   int       prodSlot;
   int       curSlot;
   string    curName;
   logic     readErrArmed = 1'b0;
   logic     writeErrArmed = 1'b0;
   axiAddr_t errAddr;
   axiR_t    rBeat;
   axiW_t    wBeat;
   axiAddr_t awAddr;
   logic     rPend = 1'b0;
   logic     awDone = 1'b0;
   logic     wDone = 1'b0;
   int       arWait = 0;
   int       rWait = 0;
   int       awWait = 0;
   int       wWait = 0;
   int       bWait = 0;
   axiAddr_t arLog [$];
   wrRec_t   wrLog [$];

   int checkCount = 0;
   int mismatchCount = 0;
   int failCount = 0;

   tbClock #(.PeriodNs(ClkPeriod)) clkGen0 (.clk(clk));

   pcieSubTop dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .ar         (ar),
      .arReady    (arReady),
      .r          (r),
      .rReady     (rReady),
      .aw         (aw),
      .awReady    (awReady),
      .w          (w),
      .wReady     (wReady),
      .b          (b),
      .bReady     (bReady),
      .blockReady (blockReady),
      .blockDone  (blockDone),
      .bufRdEn    (bufRdEn),
      .bufRdAddr  (bufRdAddr),
      .bufRdData  (bufRdData)
   );

   function automatic axiAddr_t blockAddr(input int slot, input int idx);
      return (axiAddr_t'(slot) << `SLOT_LSB) + axiAddr_t'(idx) * `WORD_STRIDE;
   endfunction

   function automatic word_t patternWord(input axiAddr_t addr);
      return addr[31:0] ^ 32'hA5A5_0000;
   endfunction

   // Descriptor reads return the producer slot, block reads the address pattern
   function automatic axiData_t beatData(input axiAddr_t addr);
      if (addr == `PROD_PTR_ADDR) return axiData_t'(prodSlot) << `SLOT_LSB;
      return {~addr, ~patternWord(addr), patternWord(addr)};
   endfunction

   always @(posedge clk) begin
      if (ar.valid && arReady) begin
         arReady <= 1'b0;
         arLog.push_back(ar.addr);
         checkBeatAttrs("ar", ar);
         rBeat = '{valid: 1'b1, data: beatData(ar.addr), resp: 2'b00, last: 1'b1};
         if (readErrArmed && ar.addr == errAddr) begin
            rBeat.resp   = 2'b10;
            readErrArmed = 1'b0;
         end
         rPend  = 1'b1;
         arWait = $urandom_range(3, 0);
      end else if (ar.valid) begin
         if (arWait == 0) arReady <= 1'b1;
         else arWait--;
      end
      if (r.valid && rReady) begin
         r     <= '0;
         rWait = $urandom_range(3, 0);
      end else if (rPend) begin
         if (rWait == 0) begin
            r     <= rBeat;
            rPend = 1'b0;
         end else begin
            rWait--;
         end
      end

      // Address and data channels accept independently
      if (aw.valid && awReady) begin
         awReady <= 1'b0;
         awAddr  = aw.addr;
         awDone  = 1'b1;
         awWait  = $urandom_range(3, 0);
         checkBeatAttrs("aw", aw);
      end else if (aw.valid) begin
         if (awWait == 0) awReady <= 1'b1;
         else awWait--;
      end
      if (w.valid && wReady) begin
         wReady <= 1'b0;
         wBeat  = w;
         wDone  = 1'b1;
         wWait  = $urandom_range(3, 0);
      end else if (w.valid) begin
         if (wWait == 0) wReady <= 1'b1;
         else wWait--;
      end
      if (b.valid && bReady) begin
         b     <= '0;
         bWait = $urandom_range(3, 0);
      end else if (awDone && wDone) begin
         if (bWait == 0) begin
            b <= '{valid: 1'b1, resp: writeErrArmed ? 2'b10 : 2'b00};
            wrLog.push_back('{addr: awAddr, data: wBeat.data, strb: wBeat.strb,
                              last: wBeat.last});
            writeErrArmed = 1'b0;
            awDone        = 1'b0;
            wDone         = 1'b0;
         end else begin
            bWait--;
         end
      end
   end

   task automatic check(input string name, input logic [127:0] expected,
                        input logic [127:0] actual);
      checkCount++;
      if (actual !== expected) begin
         mismatchCount++;
         $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // Fixed attributes of every single-beat transfer
   task automatic checkBeatAttrs(input string chan, input axiAr_t a);
      check({curName, " ", chan, " len"}, 8'd0, a.len);
      check({curName, " ", chan, " size"}, 3'd4, a.size);
      check({curName, " ", chan, " burst"}, 2'b01, a.burst);
      check({curName, " ", chan, " id"}, 4'd0, a.id);
      check({curName, " ", chan, " prot"}, 3'd2, a.prot);
      check({curName, " ", chan, " lock cache qos"}, 9'd0, {a.lock, a.cache, a.qos});
   endtask

   task automatic noteFailure(input string msg);
      failCount++;
      $display("Error: %s", msg);
   endtask

   task automatic readBuffer(input bufAddr_t idx, output word_t data);
      @(posedge clk);
      bufRdEn   <= 1'b1;
      bufRdAddr <= idx;
      @(posedge clk);
      bufRdEn <= 1'b0;
      @(negedge clk);
      data = bufRdData;
   endtask

   task automatic releaseBlock();
      @(posedge clk);
      blockDone <= 1'b1;
      @(posedge clk);
      blockDone <= 1'b0;
   endtask

   task automatic runNoop(input int i);
      logic sawWrite;
      logic sawReady;
      sawWrite = 1'b0;
      sawReady = 1'b0;
      repeat (3 * PollCycles) begin
         @(negedge clk);
         sawWrite |= aw.valid;
         sawReady |= blockReady;
      end
      if (sawWrite) noteFailure($sformatf("%s: pointer write started without a new slot",
                                          rowName[i]));
      if (sawReady) noteFailure($sformatf("%s: blockReady rose without a new slot",
                                          rowName[i]));
      if (arLog.size() < 2) noteFailure($sformatf("%s: polling did not run", rowName[i]));
      foreach (arLog[k]) check($sformatf("%s poll %0d", rowName[i], k), `PROD_PTR_ADDR, arLog[k]);
   endtask

   task automatic runFetch(input int i);
      axiAddr_t expAddr [$];
      word_t    data;
      int       arCount;
      logic     dropped;
      expAddr.push_back(`PROD_PTR_ADDR);
      for (int n = 0; n < `BLOCK_WORDS; n++) begin
         expAddr.push_back(blockAddr(curSlot, n));
         if (n == rows[i].errWord) expAddr.push_back(blockAddr(curSlot, n));
      end
      do begin
         @(negedge clk);
      end while (!blockReady);

      if (arLog.size() != expAddr.size())
         noteFailure($sformatf("%s: %0d reads seen, %0d expected", rowName[i],
                               arLog.size(), expAddr.size()));
      for (int n = 0; n < expAddr.size() && n < arLog.size(); n++)
         check($sformatf("%s read %0d", rowName[i], n), expAddr[n], arLog[n]);
      if (wrLog.size() != (rows[i].wrErr ? 2 : 1))
         noteFailure($sformatf("%s: %0d pointer writes seen", rowName[i], wrLog.size()));
      foreach (wrLog[k]) begin
         check($sformatf("%s ptr addr", rowName[i]), `CONS_PTR_ADDR, wrLog[k].addr);
         check($sformatf("%s ptr data", rowName[i]),
               axiData_t'(rows[i].expSlot) << `SLOT_LSB, wrLog[k].data);
         check($sformatf("%s ptr strb", rowName[i]), {(`AXI_DATA_W/8){1'b1}},
               wrLog[k].strb);
         check($sformatf("%s ptr last", rowName[i]), 1'b1, wrLog[k].last);
      end

      // Handoff holds and blocks polling until blockDone
      arCount = arLog.size();
      dropped = 1'b0;
      repeat (PollCycles + 4) begin
         @(negedge clk);
         dropped |= !blockReady;
      end
      if (dropped) noteFailure($sformatf("%s: blockReady fell before blockDone", rowName[i]));
      if (arLog.size() != arCount)
         noteFailure($sformatf("%s: poll read issued during handoff", rowName[i]));

      for (int n = 0; n < `BLOCK_WORDS; n++) begin
         readBuffer(bufAddr_t'(n), data);
         check($sformatf("%s buffer %0d", rowName[i], n),
               patternWord(blockAddr(curSlot, n)), data);
      end
   endtask

   initial begin
      logic handoffOpen;
      void'($urandom(67));
      rst_n       = 1'b0;
      blockDone   = 1'b0;
      bufRdEn     = 1'b0;
      bufRdAddr   = '0;
      prodSlot    = `INIT_SLOT;
      curSlot     = `INIT_SLOT;
      handoffOpen = 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < NumRows; i++) begin
         @(negedge clk);
         arLog.delete();
         wrLog.delete();
         curName       = rowName[i];
         prodSlot      = rows[i].prodSlot;
         writeErrArmed = rows[i].wrErr;
         readErrArmed  = (rows[i].errWord < NoErr);
         errAddr       = blockAddr(curSlot, rows[i].errWord);
         if (handoffOpen) releaseBlock();
         if (rows[i].prodSlot == curSlot) runNoop(i);
         else runFetch(i);
         handoffOpen = (rows[i].prodSlot != curSlot);
         curSlot     = rows[i].expSlot;
      end

      $display("Checks %0d, mismatches %0d, other errors %0d",
               checkCount, mismatchCount, failCount);
      if (mismatchCount == 0 && failCount == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      #(WatchdogCycles * ClkPeriod);
      $display("Watchdog expired: the run did not finish within %0d cycles", WatchdogCycles);
      $display("TESTBENCH FAILED");
      $finish;
   end
endmodule

// File: all.f
+incdir+rtl
rtl/axiPkg.sv
rtl/fetchPkg.sv
rtl/axiReadReq.sv
rtl/axiWriteReq.sv
rtl/ibBuffer.sv
rtl/ibFetchCtlr.sv
rtl/pcieSubTop.sv
verification/tbClock.sv
verification/pcieSubTb.sv

// File: run.sh
#!/bin/sh
# Build and run the pcieSubTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module pcieSubTb -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
   exit 0
fi
exit 1
